//--- clause_array.f
sat_var_pkg.sv
clause_pkg.sv
lit_cell.sv
lit_row.sv
clause_terminal.sv
clause_cell.sv
clause_array.sv
tb_clock.sv
clause_array_tb.sv

//--- clause_array.sv
`default_nettype none

module clause_array
    import sat_var_pkg::*;
#(
    parameter int NUM_VARS    = 8,
    parameter int NUM_CLAUSES = 4,
    parameter int WIDTH_C_LEN = 4
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  var_info_t [NUM_VARS-1:0]                   var_info_i,
    input  logic      [NUM_CLAUSES-1:0]                wr_i,
    input  logic      [NUM_CLAUSES-1:0]                rd_i,
    input  lit_e      [NUM_VARS-1:0]                   clause_i,
    input  logic      [WIDTH_C_LEN-1:0]                clause_len_i,
    input  logic                                       apply_imply_i,
    input  logic                                       apply_analyze_i,
    input  logic                                       apply_bkt_i,
    output var_info_t [NUM_VARS-1:0]                   var_info_o,
    output lit_e      [NUM_VARS-1:0]                   clause_o,
    output logic      [NUM_CLAUSES-1:0][WIDTH_C_LEN-1:0] clause_len_o,
    output logic      [NUM_VARS-1:0]                   participate_o,
    output logic                                       all_c_sat_o,
    output logic                                       conflict_o
);

    var_info_t [NUM_VARS-1:0] var_chain [NUM_CLAUSES+1];
    lit_e      [NUM_VARS-1:0] cell_clause [NUM_CLAUSES];
    logic      [NUM_VARS-1:0] cell_part [NUM_CLAUSES];
    logic [NUM_CLAUSES-1:0]   cell_sat_or_empty;
    logic [NUM_CLAUSES-1:0]   cell_conflict;

    // ####################################################################
    // clause chain
    // ####################################################################

    assign var_chain[0] = var_info_i;  // earlier cells win on a shared variable.

    for (genvar k = 0; k < NUM_CLAUSES; k++) begin : g_clause
        clause_cell #(
            .NUM_VARS    (NUM_VARS),
            .WIDTH_C_LEN (WIDTH_C_LEN)
        ) clause_cell_inst (
            .clk             (clk),
            .rst             (rst),
            .wr_i            (wr_i[k]),
            .rd_i            (rd_i[k]),
            .clause_i        (clause_i),
            .clause_len_i    (clause_len_i),
            .var_i           (var_info_i),
            .var_down_i      (var_chain[k]),
            .apply_imply_i   (apply_imply_i),
            .apply_analyze_i (apply_analyze_i),
            .apply_bkt_i     (apply_bkt_i),
            .var_down_o      (var_chain[k+1]),
            .clause_o        (cell_clause[k]),
            .clause_len_o    (clause_len_o[k]),
            .participate_o   (cell_part[k]),
            .sat_or_empty_o  (cell_sat_or_empty[k]),
            .conflict_o      (cell_conflict[k])
        );
    end

    assign var_info_o = var_chain[NUM_CLAUSES];

    // ####################################################################
    // combined outputs
    // ####################################################################

    always_comb begin
        for (int i = 0; i < NUM_VARS; i++) begin
            clause_o[i] = LIT_NONE;
        end
        for (int k = 0; k < NUM_CLAUSES; k++) begin
            for (int i = 0; i < NUM_VARS; i++) begin
                clause_o[i] = lit_e'(clause_o[i] | cell_clause[k][i]);  // unread cells give 0.
            end
        end
    end

    always_comb begin
        participate_o = '0;
        for (int k = 0; k < NUM_CLAUSES; k++) begin
            participate_o = participate_o | cell_part[k];
        end
    end

    assign all_c_sat_o = &cell_sat_or_empty;
    assign conflict_o  = |cell_conflict;

    a_wr_onehot : assert property (@(posedge clk) disable iff (!rst) $onehot0(wr_i))
        else $error("clause_array: more than one clause write strobe");

endmodule

`default_nettype wire

//--- clause_array_tb.sv
`default_nettype none

module clause_array_tb
    import sat_var_pkg::*;
;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NV = 8;
    localparam int NC = 4;
    localparam int CL = 4;

    typedef struct {
        string                    name;
        logic [NC-1:0]            wr;
        logic [NC-1:0]            rd;
        lit_e [NV-1:0]            clause;
        logic [CL-1:0]            len;
        var_info_t [NV-1:0]       vin;
        logic                     imply;
        logic                     analyze;
        logic                     bkt;
        logic [NV-1:0]            fill;  // random level for free vars in no clause.
        var_info_t [NV-1:0]       exp_vout;
        lit_e [NV-1:0]            exp_clause;
        logic                     exp_conf;
        logic                     exp_sat;
        logic [NV-1:0]            exp_part;
        logic [NC-1:0][CL-1:0]    exp_len;
    } test_t;

    logic clk;
    logic rst;
    var_info_t [NV-1:0]       var_info_i;
    logic [NC-1:0]            wr_i;
    logic [NC-1:0]            rd_i;
    lit_e [NV-1:0]            clause_i;
    logic [CL-1:0]            clause_len_i;
    logic                     apply_imply_i;
    logic                     apply_analyze_i;
    logic                     apply_bkt_i;
    var_info_t [NV-1:0]       var_info_o;
    lit_e [NV-1:0]            clause_o;
    logic [NC-1:0][CL-1:0]    clause_len_o;
    logic [NV-1:0]            participate_o;
    logic                     all_c_sat_o;
    logic                     conflict_o;

    test_t  tests[$];
    integer seed = 8438;
    int     errors = 0;
    int     checks = 0;

    tb_clock #(.RST_CYCLES(8)) tb_clock_inst (.clk_o(clk), .rst_o(rst));

    clause_array #(
        .NUM_VARS    (NV),
        .NUM_CLAUSES (NC),
        .WIDTH_C_LEN (CL)
    ) clause_array_inst (
        .clk (clk), .rst (rst), .var_info_i (var_info_i), .wr_i (wr_i), .rd_i (rd_i),
        .clause_i (clause_i), .clause_len_i (clause_len_i), .apply_imply_i (apply_imply_i),
        .apply_analyze_i (apply_analyze_i), .apply_bkt_i (apply_bkt_i),
        .var_info_o (var_info_o), .clause_o (clause_o), .clause_len_o (clause_len_o),
        .participate_o (participate_o), .all_c_sat_o (all_c_sat_o), .conflict_o (conflict_o)
    );

    function automatic var_info_t mk_var(var_value_e v, int lvl);
        var_info_t r;
        r.value = v;
        r.lvl   = lvl[LVL_W-1:0];
        return r;
    endfunction

    function automatic lit_e [NV-1:0] mk_lits(logic [NV-1:0] pos, logic [NV-1:0] neg);
        lit_e [NV-1:0] r;
        for (int i = 0; i < NV; i++) begin
            r[i] = pos[i] ? LIT_POS : (neg[i] ? LIT_NEG : LIT_NONE);
        end
        return r;
    endfunction

    function automatic test_t new_test(string name);
        test_t t;
        t.name = name;
        t.wr = '0;
        t.rd = '0;
        t.clause = mk_lits('0, '0);
        t.len = '0;
        for (int i = 0; i < NV; i++) begin
            t.vin[i] = mk_var(VAR_FREE, 0);
        end
        t.imply = 1'b0;
        t.analyze = 1'b0;
        t.bkt = 1'b0;
        t.fill = '0;
        t.exp_vout = t.vin;
        t.exp_clause = mk_lits('0, '0);
        t.exp_conf = 1'b0;
        t.exp_sat = 1'b0;
        t.exp_part = '0;
        t.exp_len = '0;
        return t;
    endfunction

    // ####################################################################
    // compare tasks
    // ####################################################################

    task automatic check_vars(string name, var_info_t [NV-1:0] exp, var_info_t [NV-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s var_info_o expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_lits(string name, lit_e [NV-1:0] exp, lit_e [NV-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s clause_o expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_lens(string name, logic [NC-1:0][CL-1:0] exp,
                              logic [NC-1:0][CL-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s clause_len_o expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(string name, string what, logic exp, logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s %s expected %b actual %b", name, what, exp, act);
        end
    endtask

    task automatic check_mask(string name, logic [NV-1:0] exp, logic [NV-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s participate_o expected %h actual %h", name, exp, act);
        end
    endtask

    // ####################################################################
    // stimulus table
    // ####################################################################

    task automatic build_table();
        test_t                 t;
        logic [NC-1:0][CL-1:0] stored;
        stored = '0;
        t = new_test("reset_state");
        t.fill = 8'hff;
        t.exp_sat = 1'b1;  // every cell empty.
        tests.push_back(t);
        t = new_test("write_c0");  // x0 | !x1 | x2.
        t.wr = 4'b0001;
        t.rd = 4'b0001;
        t.len = 3;
        t.fill = 8'hf8;
        t.clause = mk_lits(8'h05, 8'h02);
        t.exp_clause = t.clause;
        stored[0] = t.len;
        t.exp_len = stored;
        tests.push_back(t);
        t = new_test("write_c1");  // !x0 | x3.
        t.wr = 4'b0010;
        t.rd = 4'b0010;
        t.len = 2;
        t.fill = 8'hf0;
        t.clause = mk_lits(8'h08, 8'h01);
        t.exp_clause = t.clause;
        stored[1] = t.len;
        t.exp_len = stored;
        tests.push_back(t);
        t = new_test("write_c2");  // x0 | x4.
        t.wr = 4'b0100;
        t.rd = 4'b0100;
        t.len = 2;
        t.fill = 8'he0;
        t.clause = mk_lits(8'h11, 8'h00);
        t.exp_clause = t.clause;
        stored[2] = t.len;
        t.exp_len = stored;
        tests.push_back(t);
        t = new_test("imply_unit");
        t.vin[1] = mk_var(VAR_TRUE, 3);
        t.vin[2] = mk_var(VAR_FALSE, 5);
        t.imply = 1'b1;
        t.fill = 8'he0;
        t.exp_vout = t.vin;
        t.exp_vout[0] = mk_var(VAR_IMP_TRUE, 5);  // max false level.
        t.exp_len = stored;
        t.exp_len[0] = '0;  // c0 now a reason.
        tests.push_back(t);
        t = new_test("imply_priority");
        t.vin[1] = mk_var(VAR_TRUE, 3);
        t.vin[2] = mk_var(VAR_FALSE, 5);
        t.vin[3] = mk_var(VAR_FALSE, 7);
        t.fill = 8'he0;
        t.exp_vout = t.vin;
        t.exp_vout[0] = mk_var(VAR_IMP_TRUE, 5);  // c0 beats c1.
        t.exp_len = stored;
        t.exp_len[0] = '0;
        tests.push_back(t);
        t = new_test("conflict_analyze");
        t.vin[0] = mk_var(VAR_FALSE, 2);
        t.vin[1] = mk_var(VAR_TRUE, 3);
        t.vin[2] = mk_var(VAR_FALSE, 5);
        t.analyze = 1'b1;
        t.fill = 8'he0;
        t.exp_vout = t.vin;
        t.exp_vout[4] = mk_var(VAR_IMP_TRUE, 2);  // c2 unit on x4.
        t.exp_conf = 1'b1;
        t.exp_part = 8'h07;
        t.exp_len = stored;
        t.exp_len[0] = '0;
        tests.push_back(t);
        t = new_test("backtrack");
        t.bkt = 1'b1;
        t.fill = 8'he0;
        t.exp_len = stored;
        tests.push_back(t);
        t = new_test("all_sat");
        t.vin[0] = mk_var(VAR_TRUE, 1);
        t.vin[3] = mk_var(VAR_TRUE, 1);
        t.fill = 8'he0;
        t.exp_vout = t.vin;
        t.exp_sat = 1'b1;
        t.exp_len = stored;
        tests.push_back(t);
        t = new_test("imply_neg");
        t.vin[3] = mk_var(VAR_FALSE, 4);
        t.fill = 8'he0;
        t.exp_vout = t.vin;
        t.exp_vout[0] = mk_var(VAR_IMP_FALSE, 4);  // c1 unit on !x0.
        t.exp_len = stored;
        tests.push_back(t);
        t = new_test("write_c3");  // !x5 | !x6 | x7.
        t.wr = 4'b1000;
        t.rd = 4'b1000;
        t.len = 3;
        t.clause = mk_lits(8'h80, 8'h60);
        t.exp_clause = t.clause;
        stored[3] = t.len;
        t.exp_len = stored;
        tests.push_back(t);
    endtask

    // ####################################################################
    // run
    // ####################################################################

    initial begin
        test_t t;
        int    lvl;
        var_info_i <= '0;
        wr_i <= '0;
        rd_i <= '0;
        clause_i <= mk_lits('0, '0);
        clause_len_i <= '0;
        apply_imply_i <= 1'b0;
        apply_analyze_i <= 1'b0;
        apply_bkt_i <= 1'b0;
        build_table();
        wait (rst === 1'b1);
        foreach (tests[n]) begin
            t = tests[n];
            for (int i = 0; i < NV; i++) begin
                if (t.fill[i]) begin
                    lvl = $random(seed);
                    t.vin[i].lvl = lvl[LVL_W-1:0];
                    t.exp_vout[i].lvl = lvl[LVL_W-1:0];
                end
            end
            @(posedge clk);
            var_info_i <= t.vin;
            wr_i <= t.wr;
            rd_i <= t.rd;
            clause_i <= t.clause;
            clause_len_i <= t.len;
            apply_imply_i <= t.imply;
            apply_analyze_i <= t.analyze;
            apply_bkt_i <= t.bkt;
            @(posedge clk);
            wr_i <= '0;  // strobes last one edge.
            apply_imply_i <= 1'b0;
            apply_bkt_i <= 1'b0;
            @(negedge clk);
            check_vars(t.name, t.exp_vout, var_info_o);
            check_lits(t.name, t.exp_clause, clause_o);
            check_lens(t.name, t.exp_len, clause_len_o);
            check_flag(t.name, "conflict_o", t.exp_conf, conflict_o);
            check_flag(t.name, "all_c_sat_o", t.exp_sat, all_c_sat_o);
            check_mask(t.name, t.exp_part, participate_o);
        end
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog over 4 cycles per entry plus reset.
    initial begin
        #1;
        repeat ((tests.size() + 8) * 4) @(posedge clk);
        $display("timeout: the test loop did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- clause_cell.sv
`default_nettype none

module clause_cell
    import sat_var_pkg::*, clause_pkg::*;
#(
    parameter int NUM_VARS    = 8,
    parameter int WIDTH_C_LEN = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wr_i,
    input  logic                        rd_i,
    input  lit_e      [NUM_VARS-1:0]    clause_i,
    input  logic      [WIDTH_C_LEN-1:0] clause_len_i,
    input  var_info_t [NUM_VARS-1:0]    var_i,
    input  var_info_t [NUM_VARS-1:0]    var_down_i,
    input  logic                        apply_imply_i,
    input  logic                        apply_analyze_i,
    input  logic                        apply_bkt_i,
    output var_info_t [NUM_VARS-1:0]    var_down_o,
    output lit_e      [NUM_VARS-1:0]    clause_o,
    output logic      [WIDTH_C_LEN-1:0] clause_len_o,
    output logic      [NUM_VARS-1:0]    participate_o,
    output logic                        sat_or_empty_o,
    output logic                        conflict_o
);

    lit_e [NUM_VARS-1:0]    lits_q;
    logic [WIDTH_C_LEN-1:0] len_q;
    logic                   is_reason_q;
    logic                   need_clear_q;
    logic [NUM_VARS-1:0]    var_mask;
    logic [NUM_VARS-1:0]    free_lits;
    row_status_t            status;
    term_ctrl_t             ctrl;

    lit_row #(
        .NUM_VARS (NUM_VARS)
    ) lit_row_inst (
        .lits_i     (lits_q),
        .var_i      (var_i),
        .var_down_i (var_down_i),
        .var_down_o (var_down_o),
        .ctrl_i     (ctrl),
        .status_o   (status)
    );

    clause_terminal clause_terminal_inst (
        .status_i (status),
        .ctrl_o   (ctrl)
    );

    // ####################################################################
    // clause storage and reason tracking
    // ####################################################################

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NUM_VARS; i++) begin
                lits_q[i] <= LIT_NONE;
            end
            len_q <= '0;
        end else if (wr_i) begin
            lits_q <= clause_i;
            len_q  <= clause_len_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            is_reason_q <= 1'b0;
        end else if (apply_imply_i && ctrl.imp_drv) begin
            is_reason_q <= 1'b1;  // clause became an implication reason.
        end else if (apply_bkt_i && need_clear_q) begin
            is_reason_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            need_clear_q <= 1'b0;
        end else if (is_reason_q && ctrl.conflict_drv) begin
            need_clear_q <= 1'b1;
        end else if (!is_reason_q) begin
            need_clear_q <= 1'b0;
        end
    end

    // ####################################################################
    // outputs
    // ####################################################################

    always_comb begin
        for (int i = 0; i < NUM_VARS; i++) begin
            var_mask[i]  = (lits_q[i] != LIT_NONE);
            free_lits[i] = (lits_q[i] != LIT_NONE) && (var_i[i].value == VAR_FREE);
            clause_o[i]  = rd_i ? lits_q[i] : LIT_NONE;
        end
    end

    assign clause_len_o   = is_reason_q ? '0 : len_q;  // hidden while a reason.
    assign participate_o  = (ctrl.conflict_drv && apply_analyze_i) ? var_mask : '0;
    assign sat_or_empty_o = ctrl.sat_drv || !(|var_mask);
    assign conflict_o     = ctrl.conflict_drv;

    // a reason clause had exactly one free literal when it was applied.
    a_reason_from_unit : assert property (@(posedge clk) disable iff (!rst)
        $rose(is_reason_q) |-> $past(apply_imply_i && $onehot(free_lits)))
        else $error("clause_cell: reason flag rose without a single free literal");

endmodule

`default_nettype wire

//--- clause_pkg.sv
`default_nettype none

package clause_pkg;

    // ####################################################################
    // row summary, from the literal row to the terminal
    // ####################################################################

    typedef enum logic [1:0] {
        ZERO = 2'd0,
        ONE  = 2'd1,
        MANY = 2'd2  // saturated.
    } free_cnt_e;

    typedef struct packed {
        free_cnt_e                    free_cnt;
        logic                         sat;        // some literal true.
        logic                         all_false;  // nonempty and no literal true or free.
        logic [sat_var_pkg::LVL_W-1:0] max_lvl;   // over false literals.
    } row_status_t;

    // ####################################################################
    // terminal feedback into the row
    // ####################################################################

    typedef struct packed {
        logic                          imp_drv;
        logic                          conflict_drv;
        logic                          sat_drv;
        logic [sat_var_pkg::LVL_W-1:0] imp_lvl;
    } term_ctrl_t;

endpackage

`default_nettype wire

//--- clause_terminal.sv
`default_nettype none

module clause_terminal
    import clause_pkg::*;
(
    input  row_status_t status_i,
    output term_ctrl_t  ctrl_o
);

    logic unit;

    // ####################################################################
    // implication and conflict decision
    // ####################################################################

    // unit clause: one free literal and nothing true yet.
    assign unit = !status_i.sat && (status_i.free_cnt == ONE);

    always_comb begin
        ctrl_o.imp_drv      = unit;
        ctrl_o.conflict_drv = status_i.all_false;  // row already excludes empty.
        ctrl_o.sat_drv      = status_i.sat;
        ctrl_o.imp_lvl      = status_i.max_lvl;  // highest false literal level.
    end

    // a unit clause still has a free literal, so it cannot be all false.
    always_comb begin
        assert final (!(ctrl_o.imp_drv && ctrl_o.conflict_drv))
            else $error("clause_terminal: implication and conflict together");
    end

endmodule

`default_nettype wire

//--- lit_cell.sv
`default_nettype none

module lit_cell
    import sat_var_pkg::*;
(
    input  lit_e             lit_i,
    input  var_info_t        var_i,
    input  var_info_t        var_down_i,
    input  logic             imp_drv_i,
    input  logic [LVL_W-1:0] imp_lvl_i,
    output var_info_t        var_down_o,
    output logic             is_free_o,
    output logic             is_true_o,
    output logic             is_false_o
);

    logic       val_true;
    logic       val_false;
    logic       drive_imp;
    var_value_e imp_val;

    // ####################################################################
    // literal evaluation
    // ####################################################################

    assign val_true  = var_i.value inside {VAR_TRUE, VAR_IMP_TRUE};
    assign val_false = var_i.value inside {VAR_FALSE, VAR_IMP_FALSE};

    assign is_free_o = (lit_i != LIT_NONE) && (var_i.value == VAR_FREE);

    always_comb begin
        is_true_o  = 1'b0;
        is_false_o = 1'b0;
        case (lit_i)
            LIT_POS: begin
                is_true_o  = val_true;
                is_false_o = val_false;
            end
            LIT_NEG: begin
                is_true_o  = val_false;
                is_false_o = val_true;
            end
            default: begin
                is_true_o  = 1'b0;  // absent literal.
                is_false_o = 1'b0;
            end
        endcase
    end

    // ####################################################################
    // implication onto the down chain
    // ####################################################################

    // an earlier clause already owns the variable if it is no longer free.
    assign drive_imp = imp_drv_i && is_free_o && (var_down_i.value == VAR_FREE);

    always_comb begin
        if (lit_i == LIT_POS) begin
            imp_val = VAR_IMP_TRUE;
        end else begin
            imp_val = VAR_IMP_FALSE;
        end
    end

    always_comb begin
        var_down_o = var_down_i;
        if (drive_imp) begin
            var_down_o.value = imp_val;
            var_down_o.lvl   = imp_lvl_i;
        end
    end

endmodule

`default_nettype wire

//--- lit_row.sv
`default_nettype none

module lit_row
    import sat_var_pkg::*, clause_pkg::*;
#(
    parameter int NUM_VARS = 8
) (
    input  lit_e      [NUM_VARS-1:0] lits_i,
    input  var_info_t [NUM_VARS-1:0] var_i,
    input  var_info_t [NUM_VARS-1:0] var_down_i,
    output var_info_t [NUM_VARS-1:0] var_down_o,
    input  term_ctrl_t               ctrl_i,
    output row_status_t              status_o
);

    logic [NUM_VARS-1:0] is_free;
    logic [NUM_VARS-1:0] is_true;
    logic [NUM_VARS-1:0] is_false;
    logic [NUM_VARS-1:0] present;

    for (genvar i = 0; i < NUM_VARS; i++) begin : g_lit
        lit_cell lit_cell_inst (
            .lit_i      (lits_i[i]),
            .var_i      (var_i[i]),
            .var_down_i (var_down_i[i]),
            .imp_drv_i  (ctrl_i.imp_drv),
            .imp_lvl_i  (ctrl_i.imp_lvl),
            .var_down_o (var_down_o[i]),
            .is_free_o  (is_free[i]),
            .is_true_o  (is_true[i]),
            .is_false_o (is_false[i])
        );

        assign present[i] = (lits_i[i] != LIT_NONE);
    end

    // ####################################################################
    // row summary
    // ####################################################################

    always_comb begin
        status_o.free_cnt  = ZERO;
        status_o.sat       = 1'b0;
        status_o.all_false = |present;  // empty clause is never all false.
        status_o.max_lvl   = '0;
        for (int i = 0; i < NUM_VARS; i++) begin
            if (is_free[i]) begin
                if (status_o.free_cnt == ZERO) begin
                    status_o.free_cnt = ONE;
                end else begin
                    status_o.free_cnt = MANY;
                end
            end
            status_o.sat       = status_o.sat | is_true[i];
            status_o.all_false = status_o.all_false & (is_false[i] | ~present[i]);
            if (is_false[i] && (var_i[i].lvl > status_o.max_lvl)) begin
                status_o.max_lvl = var_i[i].lvl;  // implied level source.
            end
        end
    end

    // the terminal may only imply through a single free literal.
    always_comb begin
        assert final (!ctrl_i.imp_drv || $onehot(is_free))
            else $error("lit_row: implication without exactly one free literal");
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the clause array testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f clause_array.f \
    --top-module clause_array_tb \
    -o sim_clause_array \
    && ./obj_dir/sim_clause_array | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
    && exit 0 \
    || exit 1

//--- sat_var_pkg.sv
`default_nettype none

package sat_var_pkg;

    // ####################################################################
    // decision level
    // ####################################################################

    localparam int LVL_W = 16;  // decision level width.

    // ####################################################################
    // variable and literal encodings
    // ####################################################################

    // implied values count as assigned.
    typedef enum logic [2:0] {
        VAR_FREE      = 3'd0,
        VAR_FALSE     = 3'd1,
        VAR_TRUE      = 3'd2,
        VAR_IMP_FALSE = 3'd3,
        VAR_IMP_TRUE  = 3'd4
    } var_value_e;

    typedef enum logic [1:0] {
        LIT_NONE = 2'd0,  // variable not in clause.
        LIT_POS  = 2'd1,
        LIT_NEG  = 2'd2
    } lit_e;

    // ####################################################################
    // per-variable state
    // ####################################################################

    typedef struct packed {
        var_value_e       value;
        logic [LVL_W-1:0] lvl;  // level at which it was assigned.
    } var_info_t;

endpackage

`default_nettype wire

//--- tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int RST_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_o
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;  // 100 ns period.
    end

    initial begin
        rst_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b1;
    end

endmodule

`default_nettype wire
